/* filelist.f */
rtl/tinyCorePkg.sv
rtl/regFile.sv
rtl/insnDecoder.sv
rtl/execUnit.sv
rtl/coreSequencer.sv
rtl/wordMemory.sv
rtl/coreSystem.sv
test/clockGen.sv
test/coreSystemTb.sv

/* test/coreSystemTb.sv */
`timescale 1ns/1ps
`default_nettype none

module coreSystemTb;

    localparam int cyclesPerInsn = 8;
    localparam int memDepth      = 1024;
    localparam int maxTests      = 32;
    localparam int maxLen        = 6;
    localparam tinyCorePkg::word haltWord = 32'hffff_ffff;

    logic                   clk;
    logic                   reset_n;
    logic                   restart;
    logic                   run;
    tinyCorePkg::loadReq    load;
    tinyCorePkg::storeEvent store;
    logic                   halt;

    tinyCorePkg::word progs [maxTests][maxLen];
    int               progLen [maxTests];
    tinyCorePkg::word dataA [maxTests];     // Preloaded at data address 16
    tinyCorePkg::word dataB [maxTests];     // Preloaded at data address 17
    tinyCorePkg::word expAddr [maxTests];
    tinyCorePkg::word expData [maxTests];
    logic             expHalt [maxTests];
    int               nTests;
    int               cur;
    int               errors;
    int               checks;
    int               cycleCount;
    int               cycleLimit;
    tinyCorePkg::word storeAddrQ [$];
    tinyCorePkg::word storeDataQ [$];

    clockGen #(.periodNs(40), .resetCycles(4)) clocks (.restart, .clk, .reset_n);

    coreSystem #(.cyclesPerInsn(cyclesPerInsn), .memDepth(memDepth)) uut (
        .clk, .reset_n, .run, .load, .store, .halt
    );

    function automatic tinyCorePkg::word encode(bit sw, bit st, bit deref,
                                                int z, int x, int y, int op, int imm);
        return {1'b0, sw, st, deref, z[3:0], x[3:0], y[3:0], op[3:0], imm[11:0]};
    endfunction

    function automatic tinyCorePkg::word aluModel(int op, bit sw, tinyCorePkg::word x,
                                                  tinyCorePkg::word y, tinyCorePkg::word imm);
        tinyCorePkg::word b;
        tinyCorePkg::word r;
        b = sw ? imm : y;
        case (op)
            0:  r = x | b;
            1:  r = x & b;
            2:  r = x + b;
            3:  r = x * b;
            5:  r = x << b;
            6:  r = ($signed(x) < $signed(b)) ? '1 : '0;
            7:  r = (x == b) ? '1 : '0;
            8:  r = ($signed(x) > $signed(b)) ? '1 : '0;
            9:  r = x & ~b;
            10: r = x ^ b;
            11: r = x - b;
            12: r = ~(x ^ b);
            13: r = x >> b;
            14: r = (x != b) ? '1 : '0;
            default: r = '0;                // Codes 4 and 15 are reserved
        endcase
        return r + (sw ? y : imm);
    endfunction

    task automatic startEntry(int addr, logic halts);
        cur = nTests;
        nTests++;
        progLen[cur] = 0;
        dataA[cur]   = $urandom;
        dataB[cur]   = $urandom;
        expAddr[cur] = addr;
        expHalt[cur] = halts;
    endtask

    task automatic emit(tinyCorePkg::word insn);
        progs[cur][progLen[cur]] = insn;
        progLen[cur]++;
    endtask

    task automatic buildTable();
        int t;
        int op;
        int imm;
        bit sw;
        int swapOps [4] = '{11, 10, 13, 6};
        nTests = 0;
        for (t = 0; t < 20; t++) begin
            sw = (t >= 16);
            if (sw) begin
                op = swapOps[t - 16];
            end else begin
                op = t;
            end
            startEntry(32 + t, 1'b1);
            imm = (op == 5 || op == 13) ? $urandom_range(31, 1) : $urandom_range(4095, 1);
            if (op == 5 || op == 13) begin
                dataB[cur] = dataB[cur] & 32'h1f;   // Keep shift amounts in range
            end
            emit(encode(0, 0, 1, 1, 0, 0, 0, 16));  // r1 = mem[16]
            emit(encode(0, 0, 1, 2, 0, 0, 0, 17));  // r2 = mem[17]
            emit(encode(0, 0, 0, 3, 0, 0, 0, 32 + t));
            emit(encode(sw, 1, 0, 3, 1, 2, op, imm));
            emit(haltWord);
            expData[cur] = aluModel(op, sw, dataA[cur], dataB[cur],
                                    {{20{imm[11]}}, imm[11:0]});
        end
        startEntry(64, 1'b1);                       // r0 keeps reading zero
        emit(encode(0, 0, 0, 3, 0, 0, 0, 64));
        emit(encode(0, 0, 0, 0, 0, 0, 0, 123));
        emit(encode(0, 1, 0, 3, 0, 0, 0, 0));
        emit(haltWord);
        expData[cur] = 32'd0;
        startEntry(65, 1'b1);                       // r15 store sits at address 1
        emit(encode(0, 0, 0, 3, 0, 0, 0, 65));
        emit(encode(0, 1, 0, 3, 15, 0, 0, 0));
        emit(haltWord);
        expData[cur] = 32'd1 + 32'd1;
        startEntry(66, 1'b1);                       // Copy through a load
        emit(encode(0, 0, 1, 1, 0, 0, 0, 16));
        emit(encode(0, 0, 0, 3, 0, 0, 0, 66));
        emit(encode(0, 1, 0, 3, 1, 0, 0, 0));
        emit(haltWord);
        expData[cur] = dataA[cur];
        startEntry(67, 1'b1);                       // valueZ to computed address
        emit(encode(0, 0, 1, 1, 0, 0, 0, 17));
        emit(encode(0, 1, 1, 1, 0, 0, 0, 67));
        emit(haltWord);
        expData[cur] = dataB[cur];
        startEntry(68, 1'b1);                       // Jump over the store at 2
        emit(encode(0, 0, 0, 3, 0, 0, 0, 68));
        emit(encode(0, 0, 0, 15, 0, 0, 0, 3));
        emit(encode(0, 1, 0, 3, 0, 0, 0, 111));
        emit(encode(0, 1, 0, 3, 0, 0, 0, 222));
        emit(haltWord);
        expData[cur] = 32'd222;
        startEntry(69, 1'b1);                       // Store after halt stays silent
        emit(encode(0, 0, 0, 3, 0, 0, 0, 69));
        emit(encode(0, 1, 0, 3, 0, 0, 0, 5));
        emit(haltWord);
        emit(encode(0, 1, 0, 3, 0, 0, 0, 6));
        expData[cur] = 32'd5;
        startEntry(70, 1'b0);                       // Ends in a jump to itself
        emit(encode(0, 0, 0, 3, 0, 0, 0, 70));
        emit(encode(0, 1, 0, 3, 0, 0, 0, 7));
        emit(encode(0, 0, 0, 15, 0, 0, 0, 2));
        expData[cur] = 32'd7;
    endtask

    task automatic checkValue(string name, tinyCorePkg::word got, tinyCorePkg::word want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("error at %0t: %s is %h, expected %h", $time, name, got, want);
        end
    endtask

    task automatic applyReset();
        @(posedge clk);
        #2;
        restart = 1'b1;
        @(posedge clk);
        #2;
        restart = 1'b0;
        while (!reset_n) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic loadWord(logic target, int addr, tinyCorePkg::word data);
        load = '{strobe: 1'b1, target: target, addr: addr[9:0], data: data};
        @(posedge clk);
        #2;
        load = '0;
    endtask

    task automatic sampleCycle();
        @(negedge clk);
        if (store.strobe) begin
            storeAddrQ.push_back(store.addr);
            storeDataQ.push_back(store.data);
        end
    endtask

    task automatic runEntry(int idx);
        int i;
        int waited;
        int budget;
        storeAddrQ.delete();
        storeDataQ.delete();
        applyReset();
        loadWord(1'b1, 16, dataA[idx]);
        loadWord(1'b1, 17, dataB[idx]);
        for (i = 0; i < progLen[idx]; i++) begin
            loadWord(1'b0, i, progs[idx][i]);
        end
        run = 1'b1;
        budget = (progLen[idx] + 2) * cyclesPerInsn;
        waited = 0;
        while (waited < budget && !(expHalt[idx] && halt)) begin
            sampleCycle();
            waited++;
        end
        repeat (2 * cyclesPerInsn) sampleCycle();   // Catch stores after a halt
        checkValue("halt", halt, expHalt[idx]);
        checkValue("store count", storeAddrQ.size(), 1);
        if (storeAddrQ.size() > 0) begin
            checkValue("store.addr", storeAddrQ[0], expAddr[idx]);
            checkValue("store.data", storeDataQ[0], expData[idx]);
        end
        @(posedge clk);
        #2;
        run = 1'b0;
    endtask

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("timeout: programs did not finish within %0d cycles", cycleLimit);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        int t;
        restart    = 1'b0;
        run        = 1'b0;
        load       = '0;
        errors     = 0;
        checks     = 0;
        cycleCount = 0;
        void'($urandom(32'h3a09));
        buildTable();
        cycleLimit = 20;
        for (t = 0; t < nTests; t++) begin
            cycleLimit += (progLen[t] + 4) * cyclesPerInsn + progLen[t] + 16;
        end
        for (t = 0; t < nTests; t++) begin
            runEntry(t);
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* test/clockGen.sv */
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
    parameter int periodNs    = 40,
    parameter int resetCycles = 4
) (
    input  wire logic restart,          // Starts a fresh reset on the next edge
    output logic      clk,
    output logic      reset_n
);

    int holdCount;

    initial begin
        clk = 1'b0;
        forever #(periodNs / 2) clk = ~clk;
    end

    initial begin
        reset_n   = 1'b0;
        holdCount = resetCycles;
    end

    always @(posedge clk) begin
        if (restart) begin
            holdCount <= resetCycles;
            reset_n   <= 1'b0;
        end else if (holdCount > 1) begin
            holdCount <= holdCount - 1;
        end else begin
            holdCount <= 0;
            reset_n   <= 1'b1;          // Low for resetCycles edges
        end
    end

endmodule

`default_nettype wire

/* rtl/coreSystem.sv */
`timescale 1ns/1ps
`default_nettype none

module coreSystem #(
    parameter int cyclesPerInsn = 8,
    parameter int memDepth      = 1024
) (
    input  wire logic                clk,
    input  wire logic                reset_n,
    input  wire logic                run,
    input  wire tinyCorePkg::loadReq load,
    output tinyCorePkg::storeEvent   store,
    output logic                     halt
);

    tinyCorePkg::word        fetchAddr;
    tinyCorePkg::word        fetchData;
    tinyCorePkg::word        insnWord;
    tinyCorePkg::decodedInsn decoded;
    tinyCorePkg::word        valueX;
    tinyCorePkg::word        valueY;
    tinyCorePkg::word        valueZ;
    tinyCorePkg::word        rhs;
    tinyCorePkg::word        regWriteData;
    tinyCorePkg::word        nextPc;
    tinyCorePkg::word        memAddr;
    tinyCorePkg::word        memWriteData;
    tinyCorePkg::dataWord    loadData;
    logic                    regWrite;
    logic                    memWrite;

    assign store = '{strobe: memWrite, addr: memAddr, data: memWriteData};

    coreSequencer #(.cyclesPerInsn(cyclesPerInsn)) sequencer (
        .clk, .reset_n, .run, .fetchData, .fetchAddr, .insnWord, .decoded,
        .rhs, .valueZ, .loadData, .regWrite, .regWriteData, .nextPc,
        .memAddr, .memWriteData, .memWrite, .halt
    );

    insnDecoder decoder (.insn(insnWord), .decoded);

    regFile regs (
        .clk, .reset_n,
        .enable    (run),
        .indexX    (decoded.x),
        .indexY    (decoded.y),
        .indexZ    (decoded.z),
        .writeZ    (regWrite),
        .writeData (regWriteData),
        .nextPc, .valueX, .valueY, .valueZ
    );

    execUnit exec (
        .clk, .reset_n,
        .op        (decoded.op),
        .swap      (decoded.swap),
        .operandX  (valueX),
        .operandY  (valueY),
        .immediate (decoded.immediate),
        .rhs
    );

    wordMemory #(.entryT(tinyCorePkg::word), .memDepth(memDepth)) instMem (
        .clk,
        .loadStrobe  (load.strobe && !load.target),
        .loadAddr    (load.addr),
        .loadData    (load.data),
        .writeStrobe (1'b0),        // Core never writes code
        .addr        (fetchAddr),
        .writeData   ('0),
        .readData    (fetchData)
    );

    wordMemory #(.entryT(tinyCorePkg::dataWord), .memDepth(memDepth)) dataMem (
        .clk,
        .loadStrobe  (load.strobe && load.target),
        .loadAddr    (load.addr),
        .loadData    (load.data),
        .writeStrobe (memWrite),
        .addr        (memAddr),
        .writeData   (memWriteData),
        .readData    (loadData)
    );

endmodule

`default_nettype wire

/* rtl/wordMemory.sv */
`timescale 1ns/1ps
`default_nettype none

module wordMemory #(
    parameter type entryT   = tinyCorePkg::word,
    parameter int  memDepth = 1024
) (
    input  wire logic                                 clk,
    input  wire logic                                 loadStrobe,
    input  wire logic [tinyCorePkg::loadAddrBits-1:0] loadAddr,
    input  wire entryT                                loadData,
    input  wire logic                                 writeStrobe,
    input  wire tinyCorePkg::word                     addr,
    input  wire entryT                                writeData,
    output entryT                                     readData
);

    localparam int indexBits = (memDepth > 1) ? $clog2(memDepth) : 1;

    typedef logic [indexBits-1:0] indexT;

    entryT storage [memDepth];
    indexT coreIndex;
    indexT loadIndex;
    indexT writeIndex;
    entryT writeEntry;
    logic  writeEnable;

    // Addresses wrap around the depth
    assign coreIndex = indexT'(addr % memDepth);
    assign loadIndex = indexT'(loadAddr % memDepth);

    // Load port wins over the core
    assign writeEnable = loadStrobe || writeStrobe;
    assign writeIndex  = loadStrobe ? loadIndex : coreIndex;
    assign writeEntry  = loadStrobe ? loadData : writeData;

    always_ff @(posedge clk) begin
        if (writeEnable) begin
            storage[writeIndex] <= writeEntry;
        end
    end

    assign readData = storage[coreIndex];   // Asynchronous read

endmodule

`default_nettype wire

/* rtl/coreSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module coreSequencer #(
    parameter int cyclesPerInsn = 8
) (
    input  wire logic                    clk,
    input  wire logic                    reset_n,
    input  wire logic                    run,
    input  wire tinyCorePkg::word        fetchData,
    output tinyCorePkg::word             fetchAddr,
    output tinyCorePkg::word             insnWord,
    input  wire tinyCorePkg::decodedInsn decoded,
    input  wire tinyCorePkg::word        rhs,
    input  wire tinyCorePkg::word        valueZ,
    input  wire tinyCorePkg::word        loadData,
    output logic                         regWrite,
    output tinyCorePkg::word             regWriteData,
    output tinyCorePkg::word             nextPc,
    output tinyCorePkg::word             memAddr,
    output tinyCorePkg::word             memWriteData,
    output logic                         memWrite,
    output logic                         halt
);

    localparam int phaseUnit = cyclesPerInsn / 4;
    localparam int lastCycle = cyclesPerInsn - 1;

    logic [cyclesPerInsn-1:0] ring;     // One hot, rotates every active cycle
    logic                     active;
    logic                     phase1;
    logic                     phase2;
    logic                     phase3;
    logic                     loading;
    tinyCorePkg::word         loadLatch;
    tinyCorePkg::word         result;

    assign active = run && !halt;
    assign phase1 = active && ring[phaseUnit];
    assign phase2 = active && ring[2 * phaseUnit];
    assign phase3 = active && ring[3 * phaseUnit];

    assign loading = decoded.derefRhs && !decoded.storing;
    assign result  = loading ? loadLatch : rhs;   // Loaded word replaces rhs

    // Dereference moves rhs from the data side to the address side
    assign memAddr      = decoded.derefRhs ? rhs : valueZ;
    assign memWriteData = decoded.derefRhs ? valueZ : rhs;
    assign memWrite     = phase2 && decoded.storing;

    assign regWriteData = result;
    assign regWrite     = phase3 && !decoded.storing;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            ring      <= {1'b1, {lastCycle{1'b0}}};   // Slot boundary pending
            insnWord  <= tinyCorePkg::noopInsn;
            fetchAddr <= tinyCorePkg::resetVector;
            nextPc    <= tinyCorePkg::resetVector + 32'd1;
            halt      <= 1'b0;
        end else if (active) begin
            ring <= {ring[lastCycle-1:0], ring[lastCycle]};

            // Fetched word is held from phase 0 to the end of the slot
            if (ring[lastCycle]) begin
                insnWord <= fetchData;
            end
            if (phase1) begin
                halt <= decoded.illegal;
            end
            if (phase2) begin
                fetchAddr <= decoded.branch ? result : nextPc;
            end
            if (phase3) begin
                nextPc <= fetchAddr + 32'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (phase1) begin
            loadLatch <= loadData;
        end
    end

endmodule

`default_nettype wire

/* rtl/execUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module execUnit (
    input  wire logic               clk,
    input  wire logic               reset_n,
    input  wire tinyCorePkg::opCode op,
    input  wire logic               swap,
    input  wire tinyCorePkg::word   operandX,
    input  wire tinyCorePkg::word   operandY,
    input  wire tinyCorePkg::word   immediate,
    output tinyCorePkg::word        rhs
);

    tinyCorePkg::word   operand;        // Right operand of the op
    tinyCorePkg::word   addend;         // Added in the second stage
    tinyCorePkg::word   opResult;
    tinyCorePkg::word   opStage;
    logic signed [31:0] signedX;
    logic signed [31:0] signedOp;

    assign operand  = swap ? immediate : operandY;
    assign addend   = swap ? operandY : immediate;
    assign signedX  = operandX;
    assign signedOp = operand;

    always_comb begin
        case (op)
            tinyCorePkg::opOr:          opResult = operandX | operand;
            tinyCorePkg::opAnd:         opResult = operandX & operand;
            tinyCorePkg::opAdd:         opResult = operandX + operand;
            tinyCorePkg::opMul:         opResult = operandX * operand;   // Low word only
            tinyCorePkg::opShiftLeft:   opResult = operandX << operand;
            tinyCorePkg::opLessThan:    opResult = {32{signedX < signedOp}};
            tinyCorePkg::opEqual:       opResult = {32{operandX == operand}};
            tinyCorePkg::opGreaterThan: opResult = {32{signedX > signedOp}};
            tinyCorePkg::opAndNot:      opResult = operandX & ~operand;
            tinyCorePkg::opXor:         opResult = operandX ^ operand;
            tinyCorePkg::opSub:         opResult = operandX - operand;
            tinyCorePkg::opXnor:        opResult = operandX ^~ operand;
            tinyCorePkg::opShiftRight:  opResult = operandX >> operand;  // Logical shift
            tinyCorePkg::opNotEqual:    opResult = {32{operandX != operand}};
            default:                    opResult = '0;                   // Reserved ops
        endcase
    end

    // Op result first, then the addend one cycle later
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            opStage <= '0;
            rhs     <= '0;
        end else begin
            opStage <= opResult;
            rhs     <= opStage + addend;
        end
    end

endmodule

`default_nettype wire

/* rtl/insnDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module insnDecoder (
    input  wire tinyCorePkg::word  insn,
    output tinyCorePkg::decodedInsn decoded
);

    always_comb begin
        decoded.swap      = insn[30];
        decoded.storing   = insn[29];
        decoded.derefRhs  = insn[28];                       // Memory on the right side
        decoded.z         = insn[27:24];
        decoded.x         = insn[23:20];
        decoded.y         = insn[19:16];
        decoded.op        = tinyCorePkg::opCode'(insn[15:12]);
        decoded.immediate = {{20{insn[11]}}, insn[11:0]};   // Sign-extend 12 bits
        decoded.illegal   = (insn == tinyCorePkg::illegalInsn);

        // Writing the PC register is a jump
        decoded.branch    = (insn[27:24] == 4'hf) && !insn[29];
    end

endmodule

`default_nettype wire

/* rtl/regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  wire logic                 clk,
    input  wire logic                 reset_n,
    input  wire logic                 enable,
    input  wire tinyCorePkg::regIndex indexX,
    input  wire tinyCorePkg::regIndex indexY,
    input  wire tinyCorePkg::regIndex indexZ,
    input  wire logic                 writeZ,
    input  wire tinyCorePkg::word     writeData,
    input  wire tinyCorePkg::word     nextPc,
    output tinyCorePkg::word          valueX,
    output tinyCorePkg::word          valueY,
    output tinyCorePkg::word          valueZ
);

    localparam tinyCorePkg::regIndex zeroReg = 4'd0;
    localparam tinyCorePkg::regIndex pcReg   = 4'd15;

    tinyCorePkg::word storage [1:14];   // Only the writable registers
    logic             writeOk;

    assign valueX = (indexX == zeroReg) ? '0 :
                    (indexX == pcReg)   ? nextPc : storage[indexX];
    assign valueY = (indexY == zeroReg) ? '0 :
                    (indexY == pcReg)   ? nextPc : storage[indexY];
    assign valueZ = (indexZ == zeroReg) ? '0 :
                    (indexZ == pcReg)   ? nextPc : storage[indexZ];

    // Writes to the two aliases fall away
    assign writeOk = (indexZ != zeroReg) && (indexZ != pcReg);

    always_ff @(posedge clk) begin
        if (reset_n && enable && writeZ && writeOk) begin
            storage[indexZ] <= writeData;
        end
    end

endmodule

`default_nettype wire

/* rtl/tinyCorePkg.sv */
`default_nettype none

package tinyCorePkg;

    localparam int wordBits = 32;
    localparam int loadAddrBits = 10;

    typedef logic [wordBits-1:0] word;
    typedef word dataWord;              // Data memory payload
    typedef logic [3:0] regIndex;

    typedef enum logic [3:0] {
        opOr, opAnd, opAdd, opMul,
        opReservedA, opShiftLeft, opLessThan, opEqual,
        opGreaterThan, opAndNot, opXor, opSub,
        opXnor, opShiftRight, opNotEqual, opReservedB
    } opCode;

    typedef struct packed {
        logic    swap;                  // Y and immediate trade places
        logic    storing;
        logic    derefRhs;
        regIndex z;
        regIndex x;
        regIndex y;
        opCode   op;
        word     immediate;             // Already sign-extended
        logic    illegal;
        logic    branch;                // Z is the PC and not a store
    } decodedInsn;

    typedef struct packed {
        logic                    strobe;
        logic                    target;    // 0 instruction, 1 data
        logic [loadAddrBits-1:0] addr;
        word                     data;
    } loadReq;

    typedef struct packed {
        logic strobe;
        word  addr;
        word  data;
    } storeEvent;

    localparam word resetVector = 32'h0000_0000;
    localparam word illegalInsn = 32'hffff_ffff;
    localparam word noopInsn    = 32'h0000_0000;   // r0 = r0 | r0 + 0

endpackage

`default_nettype wire
